//--- src/fp_add_pkg.sv
// shared format constants, opcode enum and pipeline structs; imported by every adder block
package fp_add_pkg;

  // single precision field widths
  localparam int EXP_W  = 8;
  localparam int FRAC_W = 23;
  localparam int SIG_W  = 24;

  // working sum is carry, 24 significand bits, guard, round and sticky
  localparam int SUM_W  = 28;

  // exponent range, unbiased
  localparam logic signed [9:0] BIAS = 10'sd127;
  localparam logic signed [9:0] EMIN = -10'sd126;
  localparam logic signed [9:0] EMAX = 10'sd127;

  // every nan result uses this one quiet encoding
  localparam logic [31:0] QNAN = 32'h7fc0_0000;

  typedef enum logic [0:0] {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fp_op_e;

  // classified operand, hidden one made explicit
  typedef struct packed {
    logic              nan;
    logic              inf;
    logic              zero;
    logic              sign;
    logic signed [9:0] exp;
    logic [SIG_W-1:0]  sig;
  } unpacked_t;

  // result fixed by nan, infinity and zero rules
  // zero result is active with nan and inf both low
  typedef struct packed {
    logic active;
    logic nan;
    logic inf;
    logic sign;
  } special_t;

  // sum before rounding, hidden one at bit SUM_W-2 once normalised
  typedef struct packed {
    logic              sign;
    logic signed [9:0] exp;
    logic [SUM_W-1:0]  mag;
  } sum_t;

endpackage

//--- src/fp_unpack.sv
// splits a single-precision word into sign, exponent and significand and classifies it
`timescale 1ns/1ps

module fp_unpack (
  input  logic [31:0]           word,
  output fp_add_pkg::unpacked_t operand
);
  import fp_add_pkg::*;

  logic              sign;
  logic [EXP_W-1:0]  exp_field;
  logic [FRAC_W-1:0] frac;

  assign {sign, exp_field, frac} = word;

  always_comb begin
    operand      = '0;
    operand.sign = sign;

    if (exp_field == '1) begin
      // all-ones exponent: infinity or nan
      operand.nan = |frac;
      operand.inf = ~|frac;
    end else if (exp_field == '0) begin
      // zero, subnormal fraction flushed, sign kept
      operand.zero = 1'b1;
    end else begin
      // normal number
      operand.exp = $signed({2'b00, exp_field}) - BIAS;
      operand.sig = {1'b1, frac};
    end
  end

endmodule

//--- src/fp_special_case.sv
// decides nan, infinity and signed zero results from the two classified operands
`timescale 1ns/1ps

module fp_special_case (
  input  fp_add_pkg::fp_op_e    op,
  input  fp_add_pkg::unpacked_t x,
  input  fp_add_pkg::unpacked_t y,
  output fp_add_pkg::special_t  special
);
  import fp_add_pkg::*;

  // y as it enters the sum, sign flipped for subtract
  logic y_sign_eff;

  assign y_sign_eff = y.sign ^ (op == OP_SUB);

  always_comb begin
    special = '0;

    if (x.nan || y.nan) begin
      special.active = 1'b1;
      special.nan    = 1'b1;
    end else if (x.inf && y.inf && (x.sign != y_sign_eff)) begin
      // opposing infinities
      special.active = 1'b1;
      special.nan    = 1'b1;
    end else if (x.inf) begin
      special.active = 1'b1;
      special.inf    = 1'b1;
      special.sign   = x.sign;
    end else if (y.inf) begin
      special.active = 1'b1;
      special.inf    = 1'b1;
      special.sign   = y_sign_eff;
    end else if (x.zero && y.zero) begin
      // -0 only when both zeros are negative
      special.active = 1'b1;
      special.sign   = x.sign & y_sign_eff;
    end

    // a single zero operand is left to the adder path
  end

endmodule

//--- src/fp_align_add.sv
// orders the operands, aligns the smaller one with sticky and adds or subtracts
`timescale 1ns/1ps

module fp_align_add (
  input  fp_add_pkg::fp_op_e    op,
  input  fp_add_pkg::unpacked_t x,
  input  fp_add_pkg::unpacked_t y,
  output fp_add_pkg::sum_t      sum
);
  import fp_add_pkg::*;

  logic             y_sign_eff;
  logic             eff_sub;
  logic             x_larger;
  unpacked_t        larger;
  unpacked_t        smaller;
  logic [9:0]       diff;
  logic [SUM_W-1:0] larger_ext;
  logic [SUM_W-1:0] smaller_ext;
  logic [SUM_W-1:0] shifted;
  logic [SUM_W-1:0] aligned;
  logic             sticky;

  assign y_sign_eff = y.sign ^ (op == OP_SUB);
  assign eff_sub    = x.sign ^ y_sign_eff;

  // a zero operand always loses, whatever its exponent field
  assign x_larger = y.zero || (!x.zero && ((x.exp > y.exp) ||
                    ((x.exp == y.exp) && (x.sig > y.sig))));

  assign larger  = x_larger ? x : y;
  assign smaller = x_larger ? y : x;

  // nonnegative for two nonzero operands
  assign diff = larger.exp - smaller.exp;

  // carry bit on top, guard/round/sticky below the significand
  assign larger_ext  = {1'b0, larger.sig, 3'b000};
  assign smaller_ext = {1'b0, smaller.sig, 3'b000};

  always_comb begin
    if (diff >= 10'(SUM_W)) begin
      // shifted right past the sticky bit
      shifted = '0;
      sticky  = |smaller.sig;
    end else begin
      shifted = smaller_ext >> diff;
      sticky  = |(smaller_ext & ~({SUM_W{1'b1}} << diff));
    end
    aligned = {shifted[SUM_W-1:1], shifted[0] | sticky};
  end

  always_comb begin
    sum.sign = x_larger ? x.sign : y_sign_eff;
    sum.exp  = larger.exp;
    // larger magnitude first, so the difference never goes negative
    if (eff_sub) begin
      sum.mag = larger_ext - aligned;
    end else begin
      sum.mag = larger_ext + aligned;
    end
  end

endmodule

//--- src/fp_normalise.sv
// normalises the raw sum after carry-out or cancellation and adjusts its exponent
`timescale 1ns/1ps

module fp_normalise (
  input  fp_add_pkg::sum_t raw,
  output fp_add_pkg::sum_t norm
);
  import fp_add_pkg::*;

  logic [4:0]       lz;
  logic [SUM_W-2:0] m;

  always_comb begin
    norm = raw;
    lz   = '0;
    m    = raw.mag[SUM_W-2:0];

    if (raw.mag[SUM_W-1]) begin
      // carry out, one place right, lost bit folded into sticky
      norm.mag = {1'b0, raw.mag[SUM_W-1:2], |raw.mag[1:0]};
      norm.exp = raw.exp + 10'sd1;
    end else begin
      // leading-zero shift in binary stages
      if (m[SUM_W-2 -: 16] == '0) begin
        m  = m << 16;
        lz = lz + 5'd16;
      end
      if (m[SUM_W-2 -: 8] == '0) begin
        m  = m << 8;
        lz = lz + 5'd8;
      end
      if (m[SUM_W-2 -: 4] == '0) begin
        m  = m << 4;
        lz = lz + 5'd4;
      end
      if (m[SUM_W-2 -: 2] == '0) begin
        m  = m << 2;
        lz = lz + 5'd2;
      end
      if (m[SUM_W-2] == 1'b0) begin
        m  = m << 1;
        lz = lz + 5'd1;
      end
      norm.mag = {1'b0, m};
      norm.exp = raw.exp - $signed({5'b00000, lz});
    end

    assert ($isunknown(raw.mag) || (raw.mag == '0) || norm.mag[SUM_W-2])
      else $error("normalised sum lost its hidden one");
  end

endmodule

//--- src/fp_round_pack.sv
// rounds to nearest even, applies overflow and flush, and packs the result word
`timescale 1ns/1ps

module fp_round_pack (
  input  fp_add_pkg::sum_t     norm,
  input  fp_add_pkg::special_t special,
  output logic [31:0]          word
);
  import fp_add_pkg::*;

  logic [SIG_W-1:0]  sig;
  logic              guard_bit;
  logic              round_bit;
  logic              sticky_bit;
  logic              round_up;
  logic [SIG_W:0]    rounded;
  logic [SIG_W-1:0]  r_sig;
  logic signed [9:0] r_exp;
  logic [9:0]        biased;

  always_comb begin
    sig        = norm.mag[SUM_W-2:3];
    guard_bit  = norm.mag[2];
    round_bit  = norm.mag[1];
    sticky_bit = norm.mag[0];

    // ties go to the even significand
    round_up = guard_bit & (round_bit | sticky_bit | sig[0]);
    rounded  = {1'b0, sig} + {{SIG_W{1'b0}}, round_up};

    r_sig = rounded[SIG_W-1:0];
    r_exp = norm.exp;
    if (rounded[SIG_W]) begin
      // all-ones significand rolled over into the exponent
      r_sig = rounded[SIG_W:1];
      r_exp = norm.exp + 10'sd1;
    end

    biased = r_exp + BIAS;
  end

  always_comb begin
    if (special.active) begin
      if (special.nan) begin
        word = QNAN;
      end else if (special.inf) begin
        word = {special.sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
      end else begin
        word = {special.sign, 31'b0};
      end
    end else if (norm.mag == '0) begin
      // exact cancellation
      word = '0;
    end else if (r_exp > EMAX) begin
      word = {norm.sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
    end else if (r_exp < EMIN) begin
      // below normal range, flushed with sign kept
      word = {norm.sign, 31'b0};
    end else begin
      word = {norm.sign, biased[EXP_W-1:0], r_sig[FRAC_W-1:0]};
    end
  end

endmodule

//--- src/fp_add_sub.sv
// two-stage single-precision add/subtract pipeline; top level with in/out valid strobes
`timescale 1ns/1ps

module fp_add_sub (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  fp_add_pkg::fp_op_e op,
  input  logic [31:0]        a,
  input  logic [31:0]        b,
  output logic               out_valid,
  output logic [31:0]        result
);
  import fp_add_pkg::*;

  unpacked_t   op_a;
  unpacked_t   op_b;
  special_t    special_d;
  special_t    special_q;
  sum_t        sum_d;
  sum_t        sum_q;
  sum_t        norm;
  logic        valid_q;
  logic [31:0] word;

  // stage 1: unpack, special rules, align and add
  fp_unpack u_unpack_a (.word(a), .operand(op_a));
  fp_unpack u_unpack_b (.word(b), .operand(op_b));

  fp_special_case u_special (.op(op), .x(op_a), .y(op_b), .special(special_d));

  fp_align_add u_align_add (.op(op), .x(op_a), .y(op_b), .sum(sum_d));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
    if (in_valid) begin
      sum_q     <= sum_d;
      special_q <= special_d;
    end
  end

  // stage 2: normalise, round and pack
  fp_normalise u_normalise (.raw(sum_q), .norm(norm));

  fp_round_pack u_round_pack (.norm(norm), .special(special_q), .word(word));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin
        result <= word;
      end
    end
  end

  // fixed two-cycle latency once reset has been high long enough
  assert property (@(posedge clk) disable iff (!rst_n)
    ($past(rst_n, 1) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
    else $error("out_valid does not follow in_valid by two cycles");

endmodule

//--- dv/fp_add_sub_tb.sv
// testbench for the two-stage fp adder; drives directed and random operations, checks each result
`timescale 1ns/1ps

module fp_add_sub_tb;
  import fp_add_pkg::*;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    fp_op_e      op;
    logic [31:0] launch;
  } txn_t;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  fp_op_e      op;
  logic [31:0] a;
  logic [31:0] b;
  logic        out_valid;
  logic [31:0] result;

  logic [31:0] cycle = 32'h0;
  int          seed;
  txn_t        pend_q[$];

  fp_add_sub dut (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .op(op),
    .a(a), .b(b), .out_valid(out_valid), .result(result)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // expected word from the format rules, finite sums computed in double precision
  function automatic logic [31:0] ref_add_sub(fp_op_e o, logic [31:0] x, logic [31:0] y);
    logic        sx;
    logic        sy;
    logic        x_nan;
    logic        y_nan;
    logic        x_inf;
    logic        y_inf;
    logic        x_zero;
    logic        y_zero;
    real         rx;
    real         ry;
    real         s;
    logic [63:0] bits;
    logic [52:0] m;
    logic [24:0] sig;
    logic        up;
    int          e;
    sx     = x[31];
    sy     = y[31] ^ (o == OP_SUB);
    x_nan  = (x[30:23] == 8'hff) && (x[22:0] != 0);
    y_nan  = (y[30:23] == 8'hff) && (y[22:0] != 0);
    x_inf  = (x[30:23] == 8'hff) && (x[22:0] == 0);
    y_inf  = (y[30:23] == 8'hff) && (y[22:0] == 0);
    // subnormals count as zero
    x_zero = (x[30:23] == 8'h00);
    y_zero = (y[30:23] == 8'h00);
    if (x_nan || y_nan) return 32'h7fc00000;
    if (x_inf && y_inf && (sx != sy)) return 32'h7fc00000;
    if (x_inf) return {sx, 8'hff, 23'h0};
    if (y_inf) return {sy, 8'hff, 23'h0};
    if (x_zero && y_zero) return {sx & sy, 31'h0};
    rx = x_zero ? 0.0 : $bitstoreal({sx, 11'(x[30:23]) + 11'd896, x[22:0], 29'h0});
    ry = y_zero ? 0.0 : $bitstoreal({sy, 11'(y[30:23]) + 11'd896, y[22:0], 29'h0});
    s  = rx + ry;
    if (s == 0.0) return 32'h0;
    bits = $realtobits(s);
    m    = {1'b1, bits[51:0]};
    // keep 24 bits, ties to even
    up   = m[28] && ((m[27:0] != 0) || m[29]);
    sig  = {1'b0, m[52:29]} + 25'(up);
    e    = int'(bits[62:52]) - 1023;
    if (sig[24]) begin
      e   = e + 1;
      sig = sig >> 1;
    end
    if (e > 127) return {bits[63], 8'hff, 23'h0};
    if (e < -126) return {bits[63], 31'h0};
    return {bits[63], 8'(e + 127), sig[22:0]};
  endfunction

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %s: got %h expected %h", name, got, expected);
      stop_run();
    end
  endtask

  task automatic apply_op(input fp_op_e o, input logic [31:0] x, input logic [31:0] y);
    txn_t t;
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    op       = o;
    a        = x;
    b        = y;
    t.a      = x;
    t.b      = y;
    t.op     = o;
    // cycle in which the inputs are driven
    t.launch = cycle;
    pend_q.push_back(t);
  endtask

  // hand-worked expectation guards the reference itself
  task automatic run_directed(input fp_op_e o, input logic [31:0] x, input logic [31:0] y,
                              input logic [31:0] expected);
    check_word($sformatf("reference a=%h b=%h op=%0d", x, y, o), ref_add_sub(o, x, y),
               expected);
    apply_op(o, x, y);
  endtask

  task automatic gen_operand(input int base, output logic [31:0] w);
    int r;
    int f;
    int e;
    r = $random(seed);
    e = base + (r % 5);
    if (r[31:28] == 4'h0) begin
      e = {$random(seed)} % 256;
    end else if (r[27:26] == 2'b00) begin
      e = base + ($random(seed) % 24);
    end
    if (e < 0) e = 0;
    if (e > 255) e = 255;
    f = $random(seed);
    w = {f[31], 8'(e), f[22:0]};
  endtask

  // compare at the falling edge, away from the output update
  always @(negedge clk) begin
    txn_t t;
    if (rst_n === 1'b1) begin
      if (out_valid === 1'b1) begin
        if (pend_q.size() == 0) begin
          $display("out_valid went high with no operation in flight");
          stop_run();
        end else begin
          t = pend_q.pop_front();
          check_word("latency", cycle - t.launch, 32'd2);
          check_word($sformatf("result a=%h b=%h op=%0d", t.a, t.b, t.op), result,
                     ref_add_sub(t.op, t.a, t.b));
        end
      end
      if ((pend_q.size() != 0) && (cycle - pend_q[0].launch > 2)) begin
        $display("operation launched at cycle %0d got no out_valid in 2 cycles",
                 pend_q[0].launch);
        stop_run();
      end
    end
  end

  initial begin
    int          base;
    int          r;
    int          n;
    logic [31:0] x;
    logic [31:0] y;
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    op          = OP_ADD;
    a           = 32'h0;
    b           = 32'h0;
    seed        = 32'hd717869e;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle pipeline stays quiet
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      #1;
      check_word("out_valid", {31'b0, out_valid}, 32'h0);
    end

    run_directed(OP_ADD, 32'h3f800000, 32'h3f800000, 32'h40000000);
    run_directed(OP_SUB, 32'h40400000, 32'h3f800000, 32'h40000000);
    run_directed(OP_SUB, 32'h40490fdb, 32'h40490fdb, 32'h00000000);
    run_directed(OP_ADD, 32'h40490fdb, 32'h00000000, 32'h40490fdb);
    run_directed(OP_ADD, 32'h80000000, 32'h80000000, 32'h80000000);
    run_directed(OP_SUB, 32'h00000000, 32'h00000000, 32'h00000000);
    run_directed(OP_ADD, 32'h7fc00001, 32'h3f800000, 32'h7fc00000);
    run_directed(OP_SUB, 32'h3f800000, 32'hffffffff, 32'h7fc00000);
    run_directed(OP_ADD, 32'h7f800000, 32'hff800000, 32'h7fc00000);
    run_directed(OP_ADD, 32'hff800000, 32'h3f800000, 32'hff800000);
    run_directed(OP_SUB, 32'h3f800000, 32'h7f800000, 32'hff800000);
    // ties, above half and rounding carry
    run_directed(OP_ADD, 32'h3f800000, 32'h33800000, 32'h3f800000);
    run_directed(OP_ADD, 32'h3f800001, 32'h33800000, 32'h3f800002);
    run_directed(OP_ADD, 32'h3f800000, 32'h33800001, 32'h3f800001);
    run_directed(OP_ADD, 32'h3fffffff, 32'h33800000, 32'h40000000);
    run_directed(OP_ADD, 32'h7f7fffff, 32'h7f7fffff, 32'h7f800000);
    run_directed(OP_SUB, 32'h80800001, 32'h80800000, 32'h80000000);
    run_directed(OP_ADD, 32'h00000001, 32'h3f800000, 32'h3f800000);
    run_directed(OP_ADD, 32'h80400000, 32'h80000001, 32'h80000000);

    for (int i = 0; i < 3000; i++) begin
      base = 1 + ({$random(seed)} % 254);
      gen_operand(base, x);
      gen_operand(base, y);
      r = $random(seed);
      if (r[3:0] == 4'h0) y = x ^ 32'h80000000;
      apply_op(fp_op_e'(r[4]), x, y);
    end

    @(posedge clk);
    #1;
    in_valid = 1'b0;
    n = 0;
    while ((pend_q.size() != 0) && (n < 20)) begin
      @(posedge clk);
      n = n + 1;
    end
    if (pend_q.size() != 0) begin
      $display("pipeline did not drain within 20 cycles");
      stop_run();
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- verilog.f
src/fp_add_pkg.sv
src/fp_unpack.sv
src/fp_special_case.sv
src/fp_align_add.sv
src/fp_normalise.sv
src/fp_round_pack.sv
src/fp_add_sub.sv
dv/fp_add_sub_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fp adder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module fp_add_sub_tb \
  -f verilog.f -o fp_add_sub_sim

status=0
./obj_dir/fp_add_sub_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Test OK" sim.log; then
  echo "simulation did not complete"
  exit 1
fi
